/* source/scan_defines.svh */
`ifndef SCAN_DEFINES_SVH
`define SCAN_DEFINES_SVH

// Number of independent matcher lanes
`define SCAN_LANES 4

// Stream contexts held by each lane
`define STREAM_COUNT 64

// Width of the stream id carried in a header beat
`define STREAM_ID_W 6

// Longest literal pattern in bytes
`define PAT_MAX 8

// Pattern length field and matcher state width
// Must hold the value PAT_MAX
`define LEN_W 4

// Match and drop counters wrap at this width
`define COUNT_W 16

`endif

/* source/scan_pkg.sv */
`include "scan_defines.svh"

package scan_pkg;

  // Kind of beat on the packet input
  typedef enum logic [1:0] {
    BEAT_IDLE = 2'd0,
    BEAT_SOP  = 2'd1,
    BEAT_DATA = 2'd2,
    BEAT_EOP  = 2'd3
  } beat_kind_t;

  // One input beat
  // Stream id and new_stream only meaningful on SOP
  typedef struct packed {
    beat_kind_t              kind;
    logic                    new_stream;
    logic [`STREAM_ID_W-1:0] stream_id;
    logic [7:0]              data;
  } scan_beat_t;

  // Per-lane configuration, pattern byte 0 is the first character
  typedef struct packed {
    logic [`PAT_MAX-1:0][7:0]   pattern;
    logic [`LEN_W-1:0]          length;
    logic [`STREAM_COUNT-1:0]   stream_enable;
  } lane_cfg_t;

  // Word selector inside one lane's register window
  typedef enum logic [2:0] {
    REG_PAT_LO = 3'd0,
    REG_PAT_HI = 3'd1,
    REG_LENGTH = 3'd2,
    REG_EN_LO  = 3'd3,
    REG_EN_HI  = 3'd4,
    REG_COUNT  = 3'd5
  } reg_sel_t;

  // Wishbone classic request and response
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

/* source/stream_dispatcher.sv */
`timescale 1ns/10ps
`include "scan_defines.svh"

module stream_dispatcher
  import scan_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  scan_beat_t         beat_in,
  output scan_beat_t         lane_beat,
  output logic [`COUNT_W-1:0] dropped_count
);

  // High between an accepted SOP and its EOP
  logic in_packet;
  // Current input beat breaks the framing rule
  logic stray;

  always_comb
  begin
    case (beat_in.kind)
      // Payload with no open packet
      BEAT_DATA, BEAT_EOP: stray = !in_packet;
      // Header while a packet is still open
      BEAT_SOP:            stray = in_packet;
      default:             stray = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      in_packet     <= 1'b0;
      lane_beat     <= '0;
      dropped_count <= '0;
    end
    else
    begin
      // Stray beats go out as IDLE so lanes never see them
      if (stray)
      begin
        lane_beat     <= '0;
        dropped_count <= dropped_count + 1'b1;
      end
      else
      begin
        lane_beat <= beat_in;
      end

      // Framing state, a stray SOP keeps the open packet
      if (!stray && beat_in.kind == BEAT_SOP)
        in_packet <= 1'b1;
      else if (!stray && beat_in.kind == BEAT_EOP)
        in_packet <= 1'b0;
    end
  end

  // Lanes must see IDLE right after any reset cycle
  assert property (@(posedge clk) !rst_n |=> lane_beat.kind == BEAT_IDLE)
    else $error("non-idle beat sent to lanes after reset");

endmodule

/* source/literal_matcher.sv */
`timescale 1ns/10ps
`include "scan_defines.svh"

module literal_matcher (
  input  logic [`PAT_MAX-1:0][7:0] cfg_pattern,
  input  logic [`LEN_W-1:0]        cfg_length,
  input  logic [`LEN_W-1:0]        state_cur,
  input  logic [7:0]               data,
  output logic [`LEN_W-1:0]        state_next,
  output logic                     hit
);

  localparam int IDX_W = $clog2(`PAT_MAX);

  // Byte continues the partial match
  logic              advance;
  // State before the restart on a full match
  logic [`LEN_W-1:0] state_cand;

  // States at or past PAT_MAX have no pattern byte to compare
  assign advance = (state_cur < `LEN_W'(`PAT_MAX)) &&
                   (data == cfg_pattern[state_cur[IDX_W-1:0]]);

  always_comb
  begin
    if (advance)
      state_cand = state_cur + 1'b1;
    // Restart rule, mismatch may still begin a new match
    else if (data == cfg_pattern[0])
      state_cand = `LEN_W'(1);
    else
      state_cand = '0;
  end

  // Length zero is an unprogrammed lane and never fires
  assign hit        = (cfg_length != '0) && (state_cand == cfg_length);
  assign state_next = hit ? '0 : state_cand;

endmodule

/* source/stream_context_lane.sv */
`timescale 1ns/10ps
`include "scan_defines.svh"

module stream_context_lane
  import scan_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  scan_beat_t          lane_beat,
  input  lane_cfg_t           cfg,
  input  logic                count_clear,
  output logic [`COUNT_W-1:0] match_count
);

  // Saved matcher state per stream
  logic [`LEN_W-1:0]        ctx_mem [`STREAM_COUNT];
  // Stream has a saved state, unsaved streams start from zero
  logic [`STREAM_COUNT-1:0] ctx_valid;

  // Live matcher state for the open packet
  logic [`LEN_W-1:0]        state_cur;
  logic [`LEN_W-1:0]        state_next;
  logic                     hit;

  // Stream id latched from the header beat
  logic [`STREAM_ID_W-1:0]  pkt_stream;
  // A hit was seen earlier in this packet
  logic                     pkt_hit;

  logic                     stream_on;
  logic                     pkt_match;
  logic                     is_eop;

  literal_matcher u_matcher (
    .cfg_pattern (cfg.pattern),
    .cfg_length  (cfg.length),
    .state_cur   (state_cur),
    .data        (lane_beat.data),
    .state_next  (state_next),
    .hit         (hit)
  );

  assign stream_on = cfg.stream_enable[pkt_stream];
  assign is_eop    = (lane_beat.kind == BEAT_EOP);
  // Include a hit on the last byte itself
  assign pkt_match = pkt_hit | hit;

  // Commit the final state only for an enabled stream
  always_ff @(posedge clk)
  begin
    if (is_eop && stream_on)
      ctx_mem[pkt_stream] <= state_next;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_cur   <= '0;
      pkt_stream  <= '0;
      pkt_hit     <= 1'b0;
      ctx_valid   <= '0;
      match_count <= '0;
    end
    else
    begin
      case (lane_beat.kind)
        BEAT_SOP:
        begin
          pkt_stream <= lane_beat.stream_id;
          pkt_hit    <= 1'b0;
          // Fresh stream or never saved starts at state zero
          if (lane_beat.new_stream || !ctx_valid[lane_beat.stream_id])
            state_cur <= '0;
          else
            state_cur <= ctx_mem[lane_beat.stream_id];
        end
        BEAT_DATA:
        begin
          state_cur <= state_next;
          pkt_hit   <= pkt_match;
        end
        BEAT_EOP:
        begin
          state_cur <= state_next;
          pkt_hit   <= pkt_match;
          if (stream_on)
            ctx_valid[pkt_stream] <= 1'b1;
        end
        default:
        begin
        end
      endcase

      // At most one count per packet, clear from software wins
      if (count_clear)
        match_count <= '0;
      else if (is_eop && stream_on && pkt_match)
        match_count <= match_count + 1'b1;
    end
  end

  // Pattern length from the register block must fit the pattern store
  assert property (@(posedge clk) disable iff (!rst_n)
    lane_beat.kind == BEAT_SOP |-> cfg.length <= `LEN_W'(`PAT_MAX))
    else $error("pattern length above PAT_MAX at packet start");

endmodule

/* source/wb_scan_regs.sv */
`timescale 1ns/10ps
`include "scan_defines.svh"

module wb_scan_regs
  import scan_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  wb_req_t                              wb_in,
  output wb_rsp_t                              wb_out,
  output lane_cfg_t [`SCAN_LANES-1:0]          lane_cfg,
  output logic [`SCAN_LANES-1:0]               count_clear,
  input  logic [`SCAN_LANES-1:0][`COUNT_W-1:0] lane_count,
  input  logic [`COUNT_W-1:0]                  dropped_count
);

  localparam int LANE_SEL_W = $clog2(`SCAN_LANES);
  // Byte address 0x80 as a word index
  localparam logic [5:0] DROP_WORD = 6'h20;

  // Word address splits into lane window and selector
  logic [5:0]            word_adr;
  logic [2:0]            lane_idx;
  logic [LANE_SEL_W-1:0] lane_sel;
  reg_sel_t              sel;
  logic                  lane_hit;
  logic                  drop_hit;

  logic                  req;
  // Request already acked, wait for the master to drop stb
  logic                  served;
  logic                  access;
  logic                  ack_q;
  logic [31:0]           dat_q;
  logic [31:0]           rd_data;

  assign word_adr = wb_in.adr[7:2];
  assign lane_idx = word_adr[5:3];
  assign lane_sel = lane_idx[LANE_SEL_W-1:0];
  assign sel      = reg_sel_t'(word_adr[2:0]);
  assign lane_hit = (lane_idx < 3'(`SCAN_LANES));
  assign drop_hit = (word_adr == DROP_WORD);

  assign req    = wb_in.cyc & wb_in.stb;
  assign access = req & !ack_q & !served;

  // Read mux, unmapped words give zero
  always_comb
  begin
    rd_data = '0;
    if (drop_hit)
      rd_data = 32'(dropped_count);
    else if (lane_hit)
    begin
      case (sel)
        REG_PAT_LO: rd_data = lane_cfg[lane_sel].pattern[3:0];
        REG_PAT_HI: rd_data = lane_cfg[lane_sel].pattern[7:4];
        REG_LENGTH: rd_data = 32'(lane_cfg[lane_sel].length);
        REG_EN_LO:  rd_data = lane_cfg[lane_sel].stream_enable[31:0];
        REG_EN_HI:  rd_data = lane_cfg[lane_sel].stream_enable[63:32];
        REG_COUNT:  rd_data = 32'(lane_count[lane_sel]);
        default:    rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ack_q       <= 1'b0;
      served      <= 1'b0;
      count_clear <= '0;
      lane_cfg    <= '0;
    end
    else
    begin
      ack_q       <= access;
      served      <= req & (served | ack_q);
      count_clear <= '0;
      // Write lands together with the ack
      if (access && wb_in.we && lane_hit)
      begin
        for (int l = 0; l < `SCAN_LANES; l++)
        begin
          if (lane_sel == LANE_SEL_W'(l))
          begin
            case (sel)
              REG_PAT_LO: lane_cfg[l].pattern[3:0]         <= wb_in.dat;
              REG_PAT_HI: lane_cfg[l].pattern[7:4]         <= wb_in.dat;
              REG_LENGTH: lane_cfg[l].length               <= wb_in.dat[`LEN_W-1:0];
              REG_EN_LO:  lane_cfg[l].stream_enable[31:0]  <= wb_in.dat;
              REG_EN_HI:  lane_cfg[l].stream_enable[63:32] <= wb_in.dat;
              REG_COUNT:  count_clear[l]                   <= 1'b1;
              default:
              begin
              end
            endcase
          end
        end
      end
    end
  end

  // Read data captured at the request edge, valid with ack
  always_ff @(posedge clk)
  begin
    if (access)
      dat_q <= rd_data;
  end

  assign wb_out.ack = ack_q;
  assign wb_out.dat = dat_q;

  // Single-cycle ack even when stb is held
  assert property (@(posedge clk) disable iff (!rst_n) wb_out.ack |=> !wb_out.ack)
    else $error("wishbone ack held for two cycles");

endmodule

/* source/packet_scanner_top.sv */
`timescale 1ns/10ps
`include "scan_defines.svh"

module packet_scanner_top
  import scan_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  scan_beat_t beat_in,
  input  wb_req_t    wb_in,
  output wb_rsp_t    wb_out
);

  // Framed beat shared by all lanes
  scan_beat_t                           lane_beat;
  logic [`COUNT_W-1:0]                  dropped_count;
  // Register block to lanes and back
  lane_cfg_t [`SCAN_LANES-1:0]          lane_cfg;
  logic [`SCAN_LANES-1:0]               count_clear;
  logic [`SCAN_LANES-1:0][`COUNT_W-1:0] lane_count;

  stream_dispatcher u_dispatcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .beat_in       (beat_in),
    .lane_beat     (lane_beat),
    .dropped_count (dropped_count)
  );

  // One matcher lane per programmable pattern
  for (genvar g = 0; g < `SCAN_LANES; g++)
  begin : g_lane
    stream_context_lane u_lane (
      .clk         (clk),
      .rst_n       (rst_n),
      .lane_beat   (lane_beat),
      .cfg         (lane_cfg[g]),
      .count_clear (count_clear[g]),
      .match_count (lane_count[g])
    );
  end

  wb_scan_regs u_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_in         (wb_in),
    .wb_out        (wb_out),
    .lane_cfg      (lane_cfg),
    .count_clear   (count_clear),
    .lane_count    (lane_count),
    .dropped_count (dropped_count)
  );

endmodule

/* bench/tb_packet_scanner.sv */
`timescale 1ns/10ps
`include "scan_defines.svh"

module tb_packet_scanner
  import scan_pkg::*;
();

  // Rough beat budget per test that sets the watchdog limit
  localparam int TEST_BEATS = 120 + 40 + 60 + 60 + 60 + 700;

  logic       clk;
  logic       rst_n;
  scan_beat_t beat_in;
  wb_req_t    wb_in;
  wb_rsp_t    wb_out;

  int errors = 0;
  int checks = 0;
  int seed   = 72;

  // Reference model of lane configuration and state
  logic [7:0]                m_pat   [`SCAN_LANES][`PAT_MAX];
  int                        m_len   [`SCAN_LANES];
  logic [`STREAM_COUNT-1:0]  m_en    [`SCAN_LANES];
  int                        m_state [`SCAN_LANES][`STREAM_COUNT];
  int                        m_count [`SCAN_LANES];
  int                        m_dropped = 0;
  // Payload of the next packet
  logic [7:0]                pkt_q [$];

  packet_scanner_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .beat_in (beat_in),
    .wb_in   (wb_in),
    .wb_out  (wb_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    #(20 * TEST_BEATS * 10);
    $display("Watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Byte address of a word in a lane window
  function automatic logic [7:0] lane_adr(input int lane, input reg_sel_t sel);
    return 8'((lane * 8 + int'(sel)) * 4);
  endfunction

  // Restart-rule matcher step for one byte
  function automatic int model_step(input int lane, input int st, input logic [7:0] b,
                                    output logic hit);
    int cand;
    if (st < `PAT_MAX && b == m_pat[lane][st])
      cand = st + 1;
    else if (b == m_pat[lane][0])
      cand = 1;
    else
      cand = 0;
    hit = (m_len[lane] != 0) && (cand == m_len[lane]);
    return hit ? 0 : cand;
  endfunction

  // One Wishbone classic cycle with ack sampled on the falling edge
  task automatic wb_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                          output logic [31:0] rdat);
    int waited;
    waited = 0;
    @(posedge clk);
    beat_in <= '0;
    wb_in   <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    @(negedge clk);
    while (!wb_out.ack && waited < 8)
    begin
      @(negedge clk);
      waited++;
    end
    if (!wb_out.ack)
    begin
      $display("ERROR %0t: no Wishbone ack for address %h", $time, adr);
      errors++;
    end
    else if (waited != 1)
    begin
      $display("ERROR %0t: Wishbone ack not one cycle after request at %h", $time, adr);
      errors++;
    end
    rdat = wb_out.dat;
    @(posedge clk);
    wb_in <= '0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read_check(input logic [7:0] adr, input logic [31:0] exp,
                               input string name);
    logic [31:0] got;
    wb_cycle(1'b0, adr, '0, got);
    checks++;
    if (got !== exp)
    begin
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // Copy the model configuration of one lane into the DUT
  task automatic program_lane(input int lane);
    wb_write(lane_adr(lane, REG_PAT_LO),
             {m_pat[lane][3], m_pat[lane][2], m_pat[lane][1], m_pat[lane][0]});
    wb_write(lane_adr(lane, REG_PAT_HI),
             {m_pat[lane][7], m_pat[lane][6], m_pat[lane][5], m_pat[lane][4]});
    wb_write(lane_adr(lane, REG_LENGTH), 32'(m_len[lane]));
    wb_write(lane_adr(lane, REG_EN_LO), m_en[lane][31:0]);
    wb_write(lane_adr(lane, REG_EN_HI), m_en[lane][63:32]);
  endtask

  task automatic set_lane(input int lane, input string pat, input logic [63:0] en);
    for (int i = 0; i < `PAT_MAX; i++)
      m_pat[lane][i] = (i < pat.len()) ? pat[i] : 8'h00;
    m_len[lane] = pat.len();
    m_en[lane]  = en;
    program_lane(lane);
  endtask

  task automatic write_enable(input int lane, input logic [63:0] en);
    m_en[lane] = en;
    wb_write(lane_adr(lane, REG_EN_LO), en[31:0]);
    wb_write(lane_adr(lane, REG_EN_HI), en[63:32]);
  endtask

  // SOP first, then pkt_q as DATA beats with EOP on the last byte
  task automatic send_queued(input logic [5:0] stream, input logic new_flag);
    scan_beat_t b;
    int         st   [`SCAN_LANES];
    logic       flag [`SCAN_LANES];
    logic       hit;
    for (int l = 0; l < `SCAN_LANES; l++)
    begin
      st[l]   = new_flag ? 0 : m_state[l][stream];
      flag[l] = 1'b0;
    end
    @(posedge clk);
    b            = '0;
    b.kind       = BEAT_SOP;
    b.new_stream = new_flag;
    b.stream_id  = stream;
    beat_in     <= b;
    for (int i = 0; i < pkt_q.size(); i++)
    begin
      @(posedge clk);
      b = '0;
      if (i == pkt_q.size() - 1)
        b.kind = BEAT_EOP;
      else
        b.kind = BEAT_DATA;
      b.data   = pkt_q[i];
      beat_in <= b;
      for (int l = 0; l < `SCAN_LANES; l++)
      begin
        st[l] = model_step(l, st[l], pkt_q[i], hit);
        if (hit)
          flag[l] = 1'b1;
      end
    end
    // Count and save only where the stream is enabled
    for (int l = 0; l < `SCAN_LANES; l++)
    begin
      if (m_en[l][stream])
      begin
        if (flag[l])
          m_count[l]++;
        m_state[l][stream] = st[l];
      end
    end
  endtask

  task automatic send_packet(input logic [5:0] stream, input logic new_flag, input string s);
    pkt_q.delete();
    for (int i = 0; i < s.len(); i++)
      pkt_q.push_back(s[i]);
    send_queued(stream, new_flag);
  endtask

  // Payload beat sent while no packet is open
  task automatic stray_beat(input beat_kind_t kind, input logic [7:0] data);
    scan_beat_t b;
    @(posedge clk);
    b        = '0;
    b.kind   = kind;
    b.data   = data;
    beat_in <= b;
    m_dropped++;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk);
      beat_in <= '0;
    end
  endtask

  task automatic check_lane_counts();
    for (int l = 0; l < `SCAN_LANES; l++)
      wb_read_check(lane_adr(l, REG_COUNT), 32'(m_count[l] % 65536),
                    $sformatf("lane%0d match_count", l));
  endtask

  task automatic after_reset_values();
    check_lane_counts();
    wb_read_check(8'h80, 32'h0, "dropped_count");
    set_lane(3, "wxyz12", 64'h8000_0000_0000_0021);
    wb_read_check(lane_adr(3, REG_PAT_LO), 32'h7a79_7877, "lane3 pattern_lo");
    wb_read_check(lane_adr(3, REG_PAT_HI), 32'h0000_3231, "lane3 pattern_hi");
    wb_read_check(lane_adr(3, REG_LENGTH), 32'd6, "lane3 length");
    wb_read_check(lane_adr(3, REG_EN_LO), 32'h0000_0021, "lane3 enable_lo");
    wb_read_check(lane_adr(3, REG_EN_HI), 32'h8000_0000, "lane3 enable_hi");
  endtask

  task automatic single_packet_match();
    set_lane(0, "GET", 64'h20);
    set_lane(1, "ZZ", 64'h20);
    set_lane(2, "ET", '1);
    send_packet(6'd5, 1'b1, "xxGETyGET");
    idle_cycles(3);
    // Two hits in one packet count once
    wb_read_check(lane_adr(0, REG_COUNT), 32'd1, "lane0 match_count");
    wb_read_check(lane_adr(1, REG_COUNT), 32'd0, "lane1 match_count");
    check_lane_counts();
  endtask

  task automatic split_packet_match();
    write_enable(0, 64'hA0);
    send_packet(6'd7, 1'b1, "..GE");
    send_packet(6'd7, 1'b0, "T..");
    idle_cycles(3);
    wb_read_check(lane_adr(0, REG_COUNT), 32'd2, "lane0 match_count");
    // Fresh stream on the second half breaks the match
    send_packet(6'd7, 1'b1, "..GE");
    send_packet(6'd7, 1'b1, "T..");
    idle_cycles(3);
    wb_read_check(lane_adr(0, REG_COUNT), 32'd2, "lane0 match_count");
  endtask

  task automatic disabled_stream_hold();
    write_enable(0, 64'h2A0);
    send_packet(6'd9, 1'b1, "zzG");
    write_enable(0, 64'h0A0);
    send_packet(6'd9, 1'b0, "GETxxGE");
    idle_cycles(3);
    wb_read_check(lane_adr(0, REG_COUNT), 32'd2, "lane0 match_count");
    // Resumes from state 1 saved after "zzG"
    write_enable(0, 64'h2A0);
    send_packet(6'd9, 1'b0, "ET");
    idle_cycles(3);
    wb_read_check(lane_adr(0, REG_COUNT), 32'd3, "lane0 match_count");
    check_lane_counts();
  endtask

  task automatic framing_and_clear();
    // Stray bytes spell lane 2's pattern on the last stream
    stray_beat(BEAT_DATA, 8'h45);
    stray_beat(BEAT_EOP, 8'h54);
    stray_beat(BEAT_DATA, 8'h47);
    idle_cycles(3);
    wb_read_check(8'h80, 32'd3, "dropped_count");
    check_lane_counts();
    wb_write(lane_adr(0, REG_COUNT), 32'h0);
    m_count[0] = 0;
    wb_read_check(lane_adr(0, REG_COUNT), 32'd0, "lane0 match_count");
    check_lane_counts();
  endtask

  task automatic random_traffic_run();
    string alpha;
    int    n;
    alpha = "ABCD";
    for (int l = 0; l < `SCAN_LANES; l++)
    begin
      m_len[l] = 1 + rand_below(4);
      for (int i = 0; i < `PAT_MAX; i++)
        m_pat[l][i] = (i < m_len[l]) ? alpha[rand_below(3)] : 8'h00;
      m_en[l] = {$random(seed), $random(seed)};
      program_lane(l);
      wb_write(lane_adr(l, REG_COUNT), 32'h0);
      m_count[l] = 0;
    end
    // Back-to-back packets over streams in both enable words
    for (int p = 0; p < 40; p++)
    begin
      n = 1 + rand_below(12);
      pkt_q.delete();
      for (int i = 0; i < n; i++)
        pkt_q.push_back(alpha[rand_below(4)]);
      send_queued(6'(rand_below(8) * 9), rand_below(4) == 0);
    end
    idle_cycles(3);
    check_lane_counts();
    wb_read_check(8'h80, 32'(m_dropped), "dropped_count");
  endtask

  initial
  begin
    rst_n   = 1'b0;
    beat_in = '0;
    wb_in   = '0;
    for (int l = 0; l < `SCAN_LANES; l++)
    begin
      m_len[l]   = 0;
      m_en[l]    = '0;
      m_count[l] = 0;
      for (int i = 0; i < `PAT_MAX; i++)
        m_pat[l][i] = 8'h00;
      for (int s = 0; s < `STREAM_COUNT; s++)
        m_state[l][s] = 0;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    after_reset_values();
    single_packet_match();
    split_packet_match();
    disabled_stream_hold();
    framing_and_clear();
    random_traffic_run();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+source
source/scan_pkg.sv
source/stream_dispatcher.sv
source/literal_matcher.sv
source/stream_context_lane.sv
source/wb_scan_regs.sv
source/packet_scanner_top.sv
bench/tb_packet_scanner.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the packet scanner and its testbench with Verilator, then run it
# The result is read back from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_packet_scanner

rm -rf obj_dir "$LOG"

verilator --binary --assert -Wno-fatal -f sources.f --top-module "$TOP" \
  && ./obj_dir/V"$TOP" > "$LOG" 2>&1

cat "$LOG" 2>/dev/null

grep -qs "ALL TESTS PASSED" "$LOG" \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }
